// ==== compile.f ====
+incdir+include
hdl/fdb_entry_pkg.sv
hdl/fdb_ctrl_pkg.sv
hdl/fdb_bucket_ram.sv
hdl/fdb_req_stage.sv
hdl/fdb_match_stage.sv
hdl/fdb_resolve_stage.sv
hdl/fdb_search_top.sv
verif/fdb_search_assert.sv
verif/fdb_search_tb.sv

// ==== hdl/fdb_bucket_ram.sv ====
`timescale 1ns/1ps

`include "fdb_config.svh"

module fdb_bucket_ram
  import fdb_entry_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        rd_en,
  input  bucket_idx_t rd_idx,
  input  logic        wr_en,
  input  bucket_idx_t wr_idx,
  input  mac_t        wr_mac,
  input  portmap_t    wr_portmap,
  output logic        rd_valid,
  output mac_t        rd_mac,
  output portmap_t    rd_portmap
);

  // entry storage, no reset on the words
  fdb_word_t mem [`FDB_DEPTH];

  // per bucket valid, cleared so the table starts empty
  logic [`FDB_DEPTH-1:0] valid;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx].mac     <= wr_mac;
      mem[wr_idx].portmap <= wr_portmap;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  // synchronous read, data one cycle after rd_en
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= valid[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_mac     <= mem[rd_idx].mac;
      rd_portmap <= mem[rd_idx].portmap;
    end
  end

endmodule

// ==== hdl/fdb_ctrl_pkg.sv ====
package fdb_ctrl_pkg;

  // search opcode, encoded like the se_source pin
  typedef enum logic {
    SE_LOOKUP = 1'b0,
    SE_LEARN  = 1'b1
  } se_op_e;

  // request stage, one search in flight at a time
  typedef enum logic {
    REQ_IDLE = 1'b0,
    REQ_BUSY = 1'b1
  } req_state_e;

endpackage

// ==== hdl/fdb_entry_pkg.sv ====
package fdb_entry_pkg;

  `include "fdb_config.svh"

  // address, port map and bucket index of the table
  typedef logic [`FDB_MAC_W-1:0]  mac_t;
  typedef logic [`FDB_PORT_W-1:0] portmap_t;
  typedef logic [`FDB_IDX_W-1:0]  bucket_idx_t;

  // one stored word of a way
  // valid bit is kept apart so reset can clear it
  typedef struct packed {
    mac_t     mac;
    portmap_t portmap;
  } fdb_word_t;

endpackage

// ==== hdl/fdb_match_stage.sv ====
`timescale 1ns/1ps

`include "fdb_config.svh"

module fdb_match_stage
  import fdb_entry_pkg::*, fdb_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        rd_en,
  input  se_op_e      req_op,
  input  mac_t        req_mac,
  input  portmap_t    req_portmap,
  input  bucket_idx_t rd_idx,
  input  logic        way0_valid,
  input  logic        way1_valid,
  input  mac_t        way0_mac,
  input  mac_t        way1_mac,
  input  portmap_t    way0_portmap,
  input  portmap_t    way1_portmap,
  output logic        cmp_vld,
  output se_op_e      cmp_op,
  output mac_t        cmp_mac,
  output portmap_t    cmp_portmap,
  output bucket_idx_t cmp_idx,
  output logic        hit0,
  output logic        hit1,
  output logic        valid0,
  output logic        valid1,
  output portmap_t    stored0_portmap,
  output portmap_t    stored1_portmap
);

  localparam int HALF_W = `FDB_MAC_W / 2;

  logic ram_vld;
  logic hit0_c;
  logic hit1_c;

  // address compared in two halves, shorter carry chains
  assign hit0_c = way0_valid &&
                  (req_mac[0+:HALF_W] == way0_mac[0+:HALF_W]) &&
                  (req_mac[HALF_W+:HALF_W] == way0_mac[HALF_W+:HALF_W]);
  assign hit1_c = way1_valid &&
                  (req_mac[0+:HALF_W] == way1_mac[0+:HALF_W]) &&
                  (req_mac[HALF_W+:HALF_W] == way1_mac[HALF_W+:HALF_W]);

  // ram output is valid one cycle after the read strobe
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ram_vld <= 1'b0;
      cmp_vld <= 1'b0;
    end else begin
      ram_vld <= rd_en;
      cmp_vld <= ram_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (ram_vld) begin
      cmp_op          <= req_op;
      cmp_mac         <= req_mac;
      cmp_portmap     <= req_portmap;
      cmp_idx         <= rd_idx;
      hit0            <= hit0_c;
      hit1            <= hit1_c;
      valid0          <= way0_valid;
      valid1          <= way1_valid;
      stored0_portmap <= way0_portmap;
      stored1_portmap <= way1_portmap;
    end
  end

endmodule

// ==== hdl/fdb_req_stage.sv ====
`timescale 1ns/1ps

module fdb_req_stage
  import fdb_entry_pkg::*, fdb_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        se_req,
  input  logic        se_source,
  input  mac_t        se_mac,
  input  portmap_t    se_portmap,
  input  bucket_idx_t se_hash,
  input  logic        se_ack,
  input  logic        se_nak,
  output logic        rd_en,
  output bucket_idx_t rd_idx,
  output se_op_e      req_op,
  output mac_t        req_mac,
  output portmap_t    req_portmap
);

  req_state_e state;

  // ====================================================================
  // idle / busy control
  // ====================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= REQ_IDLE;
      rd_en <= 1'b0;
    end else begin
      // read strobe lasts a single cycle
      rd_en <= 1'b0;
      case (state)
        REQ_IDLE: begin
          if (se_req) begin
            rd_en <= 1'b1;
            state <= REQ_BUSY;
          end
        end
        REQ_BUSY: begin
          // answer seen, back to idle on the next edge
          if (se_ack || se_nak) begin
            state <= REQ_IDLE;
          end
        end
        default: state <= REQ_IDLE;
      endcase
    end
  end

  // request fields, held until the answer
  // rd_idx also serves as bucket index downstream
  always_ff @(posedge clk) begin
    if (state == REQ_IDLE && se_req) begin
      rd_idx      <= se_hash;
      req_op      <= se_op_e'(se_source);
      req_mac     <= se_mac;
      req_portmap <= se_portmap;
    end
  end

endmodule

// ==== hdl/fdb_resolve_stage.sv ====
`timescale 1ns/1ps

module fdb_resolve_stage
  import fdb_entry_pkg::*, fdb_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        cmp_vld,
  input  se_op_e      cmp_op,
  input  mac_t        cmp_mac,
  input  portmap_t    cmp_portmap,
  input  bucket_idx_t cmp_idx,
  input  logic        hit0,
  input  logic        hit1,
  input  logic        valid0,
  input  logic        valid1,
  input  portmap_t    stored0_portmap,
  input  portmap_t    stored1_portmap,
  output logic        se_ack,
  output logic        se_nak,
  output portmap_t    se_result,
  output logic        wr_en0,
  output logic        wr_en1,
  output bucket_idx_t wr_idx,
  output mac_t        wr_mac,
  output portmap_t    wr_portmap
);

  logic     ack_c;
  logic     wr0_c;
  logic     wr1_c;
  logic     res_upd;
  portmap_t res_c;

  // ====================================================================
  // learn / lookup decision
  // ====================================================================
  always_comb begin
    ack_c   = 1'b0;
    wr0_c   = 1'b0;
    wr1_c   = 1'b0;
    res_upd = 1'b0;
    res_c   = ~cmp_portmap;
    case (cmp_op)
      SE_LEARN: begin
        // refresh a match first, then fill a free way
        if (hit0) begin
          wr0_c = 1'b1;
        end else if (hit1) begin
          wr1_c = 1'b1;
        end else if (!valid0) begin
          wr0_c = 1'b1;
        end else if (!valid1) begin
          wr1_c = 1'b1;
        end
        // bucket full with no match gives nak
        ack_c = wr0_c || wr1_c;
      end
      SE_LOOKUP: begin
        res_upd = 1'b1;
        if (hit0) begin
          ack_c = 1'b1;
          res_c = stored0_portmap;
        end else if (hit1) begin
          ack_c = 1'b1;
          res_c = stored1_portmap;
        end
        // miss floods to every port but the source ones
      end
      default: ;
    endcase
  end

  // ====================================================================
  // registered answer and table write
  // ====================================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      se_ack    <= 1'b0;
      se_nak    <= 1'b0;
      wr_en0    <= 1'b0;
      wr_en1    <= 1'b0;
      se_result <= '0;
    end else begin
      se_ack <= cmp_vld && ack_c;
      se_nak <= cmp_vld && !ack_c;
      wr_en0 <= cmp_vld && wr0_c;
      wr_en1 <= cmp_vld && wr1_c;
      // learn keeps the last lookup result
      if (cmp_vld && res_upd) begin
        se_result <= res_c;
      end
    end
  end

  // write data is shared by both ways
  always_ff @(posedge clk) begin
    if (cmp_vld) begin
      wr_idx     <= cmp_idx;
      wr_mac     <= cmp_mac;
      wr_portmap <= cmp_portmap;
    end
  end

endmodule

// ==== hdl/fdb_search_top.sv ====
`timescale 1ns/1ps

module fdb_search_top
  import fdb_entry_pkg::*, fdb_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        se_req,
  input  logic        se_source,
  input  mac_t        se_mac,
  input  portmap_t    se_portmap,
  input  bucket_idx_t se_hash,
  output logic        se_ack,
  output logic        se_nak,
  output portmap_t    se_result
);

  // request to rams and match
  logic        rd_en;
  bucket_idx_t rd_idx;
  se_op_e      req_op;
  mac_t        req_mac;
  portmap_t    req_portmap;

  // ram read data
  logic        way0_valid;
  logic        way1_valid;
  mac_t        way0_mac;
  mac_t        way1_mac;
  portmap_t    way0_portmap;
  portmap_t    way1_portmap;

  // match to resolve
  logic        cmp_vld;
  se_op_e      cmp_op;
  mac_t        cmp_mac;
  portmap_t    cmp_portmap;
  bucket_idx_t cmp_idx;
  logic        hit0;
  logic        hit1;
  logic        valid0;
  logic        valid1;
  portmap_t    stored0_portmap;
  portmap_t    stored1_portmap;

  // table write
  logic        wr_en0;
  logic        wr_en1;
  bucket_idx_t wr_idx;
  mac_t        wr_mac;
  portmap_t    wr_portmap;

  // ====================================================================
  // pipeline: request, ram read, match, resolve
  // ====================================================================
  fdb_req_stage u_req (
    .clk(clk), .rstn(rstn),
    .se_req(se_req), .se_source(se_source), .se_mac(se_mac),
    .se_portmap(se_portmap), .se_hash(se_hash),
    .se_ack(se_ack), .se_nak(se_nak),
    .rd_en(rd_en), .rd_idx(rd_idx), .req_op(req_op),
    .req_mac(req_mac), .req_portmap(req_portmap)
  );

  fdb_bucket_ram u_way0 (
    .clk(clk), .rstn(rstn),
    .rd_en(rd_en), .rd_idx(rd_idx),
    .wr_en(wr_en0), .wr_idx(wr_idx), .wr_mac(wr_mac), .wr_portmap(wr_portmap),
    .rd_valid(way0_valid), .rd_mac(way0_mac), .rd_portmap(way0_portmap)
  );

  fdb_bucket_ram u_way1 (
    .clk(clk), .rstn(rstn),
    .rd_en(rd_en), .rd_idx(rd_idx),
    .wr_en(wr_en1), .wr_idx(wr_idx), .wr_mac(wr_mac), .wr_portmap(wr_portmap),
    .rd_valid(way1_valid), .rd_mac(way1_mac), .rd_portmap(way1_portmap)
  );

  fdb_match_stage u_match (
    .clk(clk), .rstn(rstn),
    .rd_en(rd_en), .req_op(req_op), .req_mac(req_mac),
    .req_portmap(req_portmap), .rd_idx(rd_idx),
    .way0_valid(way0_valid), .way1_valid(way1_valid),
    .way0_mac(way0_mac), .way1_mac(way1_mac),
    .way0_portmap(way0_portmap), .way1_portmap(way1_portmap),
    .cmp_vld(cmp_vld), .cmp_op(cmp_op), .cmp_mac(cmp_mac),
    .cmp_portmap(cmp_portmap), .cmp_idx(cmp_idx),
    .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
    .stored0_portmap(stored0_portmap), .stored1_portmap(stored1_portmap)
  );

  fdb_resolve_stage u_resolve (
    .clk(clk), .rstn(rstn),
    .cmp_vld(cmp_vld), .cmp_op(cmp_op), .cmp_mac(cmp_mac),
    .cmp_portmap(cmp_portmap), .cmp_idx(cmp_idx),
    .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
    .stored0_portmap(stored0_portmap), .stored1_portmap(stored1_portmap),
    .se_ack(se_ack), .se_nak(se_nak), .se_result(se_result),
    .wr_en0(wr_en0), .wr_en1(wr_en1), .wr_idx(wr_idx),
    .wr_mac(wr_mac), .wr_portmap(wr_portmap)
  );

endmodule

// ==== include/fdb_config.svh ====
`ifndef FDB_CONFIG_SVH
`define FDB_CONFIG_SVH

// ====================================================================
// table geometry
// ====================================================================

// station address width
`define FDB_MAC_W 48

// one bit per switch port
`define FDB_PORT_W 16

// bucket index, width of the hash
`define FDB_IDX_W 10

// buckets per way
`define FDB_DEPTH 1024

`endif

// ==== verif/fdb_search_assert.sv ====
`timescale 1ns/1ps

module fdb_search_assert (
  input logic clk,
  input logic rstn,
  input logic se_req,
  input logic se_ack,
  input logic se_nak
);

  // failures seen so far, watched by the testbench
  int   fail_cnt = 0;
  logic busy;

  // requester side view of the single search in flight
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy <= 1'b0;
    end else if (!busy && se_req) begin
      busy <= 1'b1;
    end else if (se_ack || se_nak) begin
      busy <= 1'b0;
    end
  end

  // ====================================================================
  // answer pulses
  // ====================================================================
  a_one_answer: assert property (@(posedge clk) disable iff (!rstn)
    !(se_ack && se_nak))
    else begin
      fail_cnt++;
      $error("se_ack and se_nak high in the same cycle");
    end

  a_ack_pulse: assert property (@(posedge clk) disable iff (!rstn)
    se_ack |=> !se_ack)
    else begin
      fail_cnt++;
      $error("se_ack held longer than one cycle");
    end

  a_nak_pulse: assert property (@(posedge clk) disable iff (!rstn)
    se_nak |=> !se_nak)
    else begin
      fail_cnt++;
      $error("se_nak held longer than one cycle");
    end

  // answer rises at the third edge after acceptance
  // so it is first sampled high at the fourth
  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    (se_req && !busy) |-> ##4 (se_ack || se_nak))
    else begin
      fail_cnt++;
      $error("request not answered three cycles after acceptance");
    end

endmodule

// ==== verif/fdb_search_tb.sv ====
`timescale 1ns/1ps

module fdb_search_tb
  import fdb_entry_pkg::*, fdb_ctrl_pkg::*;
();

  localparam int NUM_ROWS    = 18;
  localparam int CYCLE_LIMIT = NUM_ROWS * 8 + 50;
  localparam int EXP_LAT     = 3;

  // one stimulus row, result is the value se_result must hold afterwards
  typedef struct packed {
    se_op_e      op;
    mac_t        mac;
    portmap_t    portmap;
    bucket_idx_t hash;
    logic        ack;
    portmap_t    result;
  } row_t;

  logic        clk;
  logic        rstn;
  logic        se_req;
  logic        se_source;
  mac_t        se_mac;
  portmap_t    se_portmap;
  bucket_idx_t se_hash;
  logic        se_ack;
  logic        se_nak;
  portmap_t    se_result;

  row_t rows [NUM_ROWS];
  int   cur_row;
  int   cycle_cnt;

  fdb_search_top i_fdb_search_top (
    .clk(clk), .rstn(rstn),
    .se_req(se_req), .se_source(se_source), .se_mac(se_mac),
    .se_portmap(se_portmap), .se_hash(se_hash),
    .se_ack(se_ack), .se_nak(se_nak), .se_result(se_result)
  );

  bind fdb_search_top fdb_search_assert u_assert (
    .clk(clk), .rstn(rstn), .se_req(se_req), .se_ack(se_ack), .se_nak(se_nak)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================================================================
  // stimulus table
  // ====================================================================
  task automatic load_table();
    // empty table, miss floods with the inverted port map
    rows[0]  = '{SE_LOOKUP, 48'h0010_a4c3_5e01, 16'h0003, 10'h005, 1'b0, 16'hfffc};
    // learn then find it
    rows[1]  = '{SE_LEARN,  48'h0010_a4c3_5e01, 16'h0011, 10'h005, 1'b1, 16'hfffc};
    rows[2]  = '{SE_LOOKUP, 48'h0010_a4c3_5e01, 16'h0000, 10'h005, 1'b1, 16'h0011};
    // refresh keeps the same way
    rows[3]  = '{SE_LEARN,  48'h0010_a4c3_5e01, 16'h0022, 10'h005, 1'b1, 16'h0011};
    rows[4]  = '{SE_LOOKUP, 48'h0010_a4c3_5e01, 16'h0000, 10'h005, 1'b1, 16'h0022};
    rows[5]  = '{SE_LEARN,  48'h0010_a4c3_5e02, 16'h0044, 10'h005, 1'b1, 16'h0022};
    rows[6]  = '{SE_LOOKUP, 48'h0010_a4c3_5e02, 16'h0000, 10'h005, 1'b1, 16'h0044};
    rows[7]  = '{SE_LOOKUP, 48'h0010_a4c3_5e01, 16'h0000, 10'h005, 1'b1, 16'h0022};
    // bucket 0x005 now full
    rows[8]  = '{SE_LEARN,  48'h0200_0000_0001, 16'h0080, 10'h005, 1'b0, 16'h0022};
    // upper half differs only
    rows[9]  = '{SE_LOOKUP, 48'h8010_a4c3_5e01, 16'h00ff, 10'h005, 1'b0, 16'hff00};
    // right address, wrong bucket
    rows[10] = '{SE_LOOKUP, 48'h0010_a4c3_5e01, 16'h0001, 10'h006, 1'b0, 16'hfffe};
    // two ways of bucket 0x3a7, third address refused
    rows[11] = '{SE_LEARN,  48'h00aa_bbcc_0001, 16'h0100, 10'h3a7, 1'b1, 16'hfffe};
    rows[12] = '{SE_LEARN,  48'h00aa_bbcc_0002, 16'h0200, 10'h3a7, 1'b1, 16'hfffe};
    rows[13] = '{SE_LOOKUP, 48'h00aa_bbcc_0001, 16'h0000, 10'h3a7, 1'b1, 16'h0100};
    rows[14] = '{SE_LOOKUP, 48'h00aa_bbcc_0002, 16'h0000, 10'h3a7, 1'b1, 16'h0200};
    rows[15] = '{SE_LEARN,  48'h00aa_bbcc_0003, 16'h0400, 10'h3a7, 1'b0, 16'h0200};
    rows[16] = '{SE_LOOKUP, 48'h00aa_bbcc_0003, 16'h0f0f, 10'h3a7, 1'b0, 16'hf0f0};
    rows[17] = '{SE_LOOKUP, 48'h00aa_bbcc_0002, 16'h0000, 10'h3a7, 1'b1, 16'h0200};
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: row %0d %s is %h, expected %h",
               $time, cur_row, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // one strobe, wait for the answer, then check it
  task automatic apply_row(input row_t r);
    int lat;
    lat        = 0;
    se_req     = 1'b1;
    se_source  = r.op;
    se_mac     = r.mac;
    se_portmap = r.portmap;
    se_hash    = r.hash;
    @(negedge clk);
    se_req = 1'b0;
    do begin
      @(negedge clk);
      lat++;
    end while (!(se_ack || se_nak));
    check_value("se_ack", se_ack, r.ack);
    check_value("se_nak", se_nak, !r.ack);
    check_value("latency", lat, EXP_LAT);
    check_value("se_result", se_result, r.result);
    // idle cycle before the next request
    @(negedge clk);
  endtask

  // ====================================================================
  // watchdogs
  // ====================================================================
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, a request was never answered", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  always @(negedge clk) begin
    if (i_fdb_search_top.u_assert.fail_cnt != 0) begin
      $display("an assertion on the search ports failed at %0t ns", $time);
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    cycle_cnt  = 0;
    cur_row    = 0;
    rstn       = 1'b0;
    se_req     = 1'b0;
    se_source  = 1'b0;
    se_mac     = '0;
    se_portmap = '0;
    se_hash    = '0;
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_value("se_result after reset", se_result, 16'h0000);
    for (int i = 0; i < NUM_ROWS; i++) begin
      cur_row = i;
      apply_row(rows[i]);
    end
    if (i_fdb_search_top.u_assert.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("TEST RESULT: FAIL");
      $fatal(1);
    end
  end

endmodule
